/* common/cgra_pkg.sv */
`default_nettype none

package cgra_pkg;

  localparam int data_w      = 16;
  localparam int num_threads = 8;
  localparam int thread_w    = 3;
  localparam int pc_w        = 8;
  localparam int rf_addr_w   = 4;
  localparam int pe_id_w     = 8;
  localparam int inst_w      = 16;
  localparam int conf_w      = 64;

  localparam int imem_depth = num_threads * (1 << pc_w);      // 2048 words
  localparam int rf_depth   = num_threads * (1 << rf_addr_w); // 128 words

  typedef enum logic [3:0] {
    ALU_NOP    = 4'd0,
    ALU_PASS_A = 4'd1,
    ALU_ADD    = 4'd2,
    ALU_SUB    = 4'd3,
    ALU_AND    = 4'd4,
    ALU_OR     = 4'd5,
    ALU_XOR    = 4'd6,
    ALU_SHL    = 4'd7,
    ALU_SHR    = 4'd8,
    ALU_SLT    = 4'd9,
    ALU_EQ     = 4'd10,
    ALU_SEL    = 4'd11
  } alu_op_e;

  typedef enum logic [2:0] {
    CONF_NOP     = 3'd0,
    CONF_INST    = 3'd1,
    CONF_CONST   = 3'd2,
    CONF_PC_MAX  = 3'd3,
    CONF_PC_LOOP = 3'd4
  } conf_cmd_e;

  // config word, msb first: cmd, id, thread, addr, data, zero pad
  localparam int conf_cmd_lsb    = 61;
  localparam int conf_id_lsb     = 53;
  localparam int conf_thread_lsb = 50;
  localparam int conf_addr_lsb   = 42;
  localparam int conf_data_lsb   = 26;

  // instruction word
  localparam int inst_op_lsb    = 12;
  localparam int inst_bsel_bit  = 11;
  localparam int inst_rfwe_bit  = 10;
  localparam int inst_oa_bit    = 9;
  localparam int inst_ob_bit    = 8;
  localparam int inst_raddr_lsb = 4;
  localparam int inst_waddr_lsb = 0;

endpackage

`default_nettype wire

/* pe/pe_conf_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_conf_reader import cgra_pkg::*; #(
  parameter logic [pe_id_w-1:0] PE_ID = '0
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire  [conf_w-1:0]    conf_bus,
  output logic                 inst_we,
  output logic [pc_w-1:0]      inst_addr,
  output logic [inst_w-1:0]    inst_data,
  output logic                 const_we,
  output logic [rf_addr_w-1:0] const_addr,
  output logic [data_w-1:0]    const_data,
  output logic                 pc_max_we,
  output logic                 pc_loop_we,
  output logic [pc_w-1:0]      pc_bound,
  output logic [thread_w-1:0]  conf_thread
);

  logic [conf_w-1:0] conf_q;
  logic              conf_vld;
  conf_cmd_e         bus_cmd;
  conf_cmd_e         cmd_q;
  logic              id_hit;

  assign bus_cmd = conf_cmd_e'(conf_bus[conf_cmd_lsb +: 3]);
  assign id_hit  = (conf_bus[conf_id_lsb +: pe_id_w] == PE_ID);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      conf_vld <= 1'b0;
    end else begin
      conf_vld <= id_hit && (bus_cmd != CONF_NOP);
    end
  end

  always_ff @(posedge clk) begin
    if (id_hit && (bus_cmd != CONF_NOP)) begin
      conf_q <= conf_bus; // held until the next matching word
    end
  end

  assign cmd_q = conf_cmd_e'(conf_q[conf_cmd_lsb +: 3]);

  assign inst_we    = conf_vld && (cmd_q == CONF_INST);
  assign const_we   = conf_vld && (cmd_q == CONF_CONST);
  assign pc_max_we  = conf_vld && (cmd_q == CONF_PC_MAX);
  assign pc_loop_we = conf_vld && (cmd_q == CONF_PC_LOOP);

  assign conf_thread = conf_q[conf_thread_lsb +: thread_w];
  assign inst_addr   = conf_q[conf_addr_lsb +: pc_w];
  assign inst_data   = conf_q[conf_data_lsb +: inst_w];
  assign const_addr  = conf_q[conf_addr_lsb +: rf_addr_w]; // low bits of addr field
  assign const_data  = conf_q[conf_data_lsb +: data_w];
  assign pc_bound    = conf_q[conf_data_lsb +: pc_w];      // bound rides in data field

  // a matched word carries exactly one known command
  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    conf_vld |-> $onehot({inst_we, const_we, pc_max_we, pc_loop_we}));

endmodule

`default_nettype wire

/* pe/pe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_ctrl import cgra_pkg::*; (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  en,
  input  wire                  inst_we,
  input  wire  [pc_w-1:0]      inst_addr,
  input  wire  [inst_w-1:0]    inst_data,
  input  wire                  pc_max_we,
  input  wire                  pc_loop_we,
  input  wire  [pc_w-1:0]      pc_bound,
  input  wire  [thread_w-1:0]  conf_thread,
  output logic                 rf_re,
  output logic [thread_w-1:0]  rf_rthread,
  output logic [rf_addr_w-1:0] rf_raddr,
  output logic                 rf_we,
  output logic [thread_w-1:0]  rf_wthread,
  output logic [rf_addr_w-1:0] rf_waddr,
  output alu_op_e              alu_op,
  output logic                 b_sel,
  output logic                 out_a_en,
  output logic                 out_b_en
);

  logic [thread_w-1:0]  thread_cnt;
  logic [pc_w-1:0]      pc      [num_threads];
  logic [pc_w-1:0]      pc_max  [num_threads];
  logic [pc_w-1:0]      pc_loop [num_threads];
  logic [pc_w-1:0]      pc_cur;
  logic [inst_w-1:0]    inst_mem [imem_depth];
  logic [inst_w-1:0]    inst_q;
  logic [inst_w-1:0]    inst;
  logic                 fetch_vld;
  logic [thread_w-1:0]  thread_dec;
  logic                 rf_we_ex;
  logic [rf_addr_w-1:0] rf_waddr_ex;
  logic [thread_w-1:0]  thread_ex;
  logic                 rf_we_wb;

  assign pc_cur = pc[thread_cnt];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thread_cnt <= '0;
      fetch_vld  <= 1'b0;
      thread_dec <= '0;
      for (int i = 0; i < num_threads; i++) begin
        pc[i] <= '0;
      end
    end else if (en) begin
      thread_cnt <= thread_cnt + 1'b1; // wraps 7 -> 0
      fetch_vld  <= 1'b1;
      thread_dec <= thread_cnt;
      pc[thread_cnt] <= (pc_cur == pc_max[thread_cnt]) ? pc_loop[thread_cnt] : pc_cur + 1'b1;
    end
  end

  // loop bounds load from config regardless of en
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < num_threads; i++) begin
        pc_max[i]  <= '0;
        pc_loop[i] <= '0;
      end
    end else begin
      if (pc_max_we)  pc_max[conf_thread]  <= pc_bound;
      if (pc_loop_we) pc_loop[conf_thread] <= pc_bound;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_we) begin
      inst_mem[{conf_thread, inst_addr}] <= inst_data;
    end
    if (en) begin
      inst_q <= inst_mem[{thread_cnt, pc_cur}]; // fetch
    end
  end

  assign inst = fetch_vld ? inst_q : '0; // NOP until the first fetch lands

  // decode drives the register file read port
  assign rf_re      = inst[inst_bsel_bit];
  assign rf_raddr   = inst[inst_raddr_lsb +: rf_addr_w];
  assign rf_rthread = thread_dec;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_op      <= ALU_NOP;
      b_sel       <= 1'b0;
      out_a_en    <= 1'b0;
      out_b_en    <= 1'b0;
      rf_we_ex    <= 1'b0;
      rf_waddr_ex <= '0;
      thread_ex   <= '0;
      rf_we_wb    <= 1'b0;
      rf_waddr    <= '0;
      rf_wthread  <= '0;
    end else if (en) begin
      alu_op      <= alu_op_e'(inst[inst_op_lsb +: 4]);
      b_sel       <= inst[inst_bsel_bit];
      out_a_en    <= inst[inst_oa_bit];
      out_b_en    <= inst[inst_ob_bit];
      rf_we_ex    <= inst[inst_rfwe_bit];
      rf_waddr_ex <= inst[inst_waddr_lsb +: rf_addr_w];
      thread_ex   <= thread_dec;
      rf_we_wb    <= rf_we_ex;    // lines up with registered wr_data
      rf_waddr    <= rf_waddr_ex;
      rf_wthread  <= thread_ex;
    end
  end

  assign rf_we = rf_we_wb && en;

  // write-back tag trails the thread counter by three turns
  a_wb_thread: assert property (@(posedge clk) disable iff (!rst_n)
    rf_we |-> (rf_wthread == thread_cnt - 3'd3));

endmodule

`default_nettype wire

/* pe/pe_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_regfile import cgra_pkg::*; (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  en,
  input  wire                  rf_re,
  input  wire  [thread_w-1:0]  rf_rthread,
  input  wire  [rf_addr_w-1:0] rf_raddr,
  input  wire                  rf_we,
  input  wire  [thread_w-1:0]  rf_wthread,
  input  wire  [rf_addr_w-1:0] rf_waddr,
  input  wire  [data_w-1:0]    wr_data,
  input  wire                  const_we,
  input  wire  [rf_addr_w-1:0] const_addr,
  input  wire  [data_w-1:0]    const_data,
  input  wire  [thread_w-1:0]  const_thread,
  output logic [data_w-1:0]    rf_data
);

  logic [data_w-1:0] rf_mem [rf_depth];

  always_ff @(posedge clk) begin
    if (const_we) begin
      rf_mem[{const_thread, const_addr}] <= const_data; // config wins the port
    end else if (rf_we) begin
      rf_mem[{rf_wthread, rf_waddr}] <= wr_data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_data <= '0;
    end else if (en && rf_re) begin
      rf_data <= rf_mem[{rf_rthread, rf_raddr}];
    end
  end

endmodule

`default_nettype wire

/* pe/pe_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module pe_exec import cgra_pkg::*; (
  input  wire               clk,
  input  wire               rst_n,
  input  wire               en,
  input  wire  [data_w-1:0] ina,
  input  wire  [data_w-1:0] inb,
  input  wire               branch_in,
  input  wire alu_op_e      alu_op,
  input  wire               b_sel,
  input  wire               out_a_en,
  input  wire               out_b_en,
  input  wire  [data_w-1:0] rf_data,
  output logic [data_w-1:0] wr_data,
  output logic [data_w-1:0] outa,
  output logic [data_w-1:0] outb,
  output logic              branch_out
);

  logic [data_w-1:0] a_s1, a_s2;
  logic [data_w-1:0] b_s1, b_s2;
  logic              br_s1, br_s2;
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] alu_res;
  logic              flag_ld;

  always_ff @(posedge clk) begin
    if (en) begin
      a_s1    <= ina;     // sampled at fetch
      b_s1    <= inb;
      a_s2    <= a_s1;
      b_s2    <= b_s1;
      wr_data <= alu_res;
    end
  end

  assign op_b = b_sel ? rf_data : b_s2;

  always_comb begin
    alu_res = '0;
    flag_ld = 1'b0;
    case (alu_op)
      ALU_PASS_A: alu_res = a_s2;
      ALU_ADD:    alu_res = a_s2 + op_b;
      ALU_SUB:    alu_res = a_s2 - op_b;
      ALU_AND:    alu_res = a_s2 & op_b;
      ALU_OR:     alu_res = a_s2 | op_b;
      ALU_XOR:    alu_res = a_s2 ^ op_b;
      ALU_SHL:    alu_res = a_s2 << op_b[3:0];
      ALU_SHR:    alu_res = a_s2 >> op_b[3:0];
      ALU_SLT: begin
        alu_res = {{(data_w-1){1'b0}}, a_s2 < op_b}; // unsigned
        flag_ld = 1'b1;
      end
      ALU_EQ: begin
        alu_res = {{(data_w-1){1'b0}}, a_s2 == op_b};
        flag_ld = 1'b1;
      end
      ALU_SEL:    alu_res = br_s2 ? a_s2 : op_b;
      default:    alu_res = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      br_s1      <= 1'b0;
      br_s2      <= 1'b0;
      outa       <= '0;
      outb       <= '0;
      branch_out <= 1'b0;
    end else if (en) begin
      br_s1 <= branch_in;
      br_s2 <= br_s1;
      if (out_a_en) outa <= alu_res;
      if (out_b_en) outb <= alu_res;
      if (flag_ld)  branch_out <= alu_res[0]; // held on other ops
    end
  end

  a_legal_op: assert property (@(posedge clk) disable iff (!rst_n)
    en |-> alu_op inside {ALU_NOP, ALU_PASS_A, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
                          ALU_XOR, ALU_SHL, ALU_SHR, ALU_SLT, ALU_EQ, ALU_SEL});

endmodule

`default_nettype wire

/* rtl/cgra_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module cgra_pe import cgra_pkg::*; #(
  parameter logic [pe_id_w-1:0] PE_ID = '0
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                en,
  input  wire  [conf_w-1:0]  conf_bus,
  input  wire  [data_w-1:0]  ina,
  input  wire  [data_w-1:0]  inb,
  input  wire                branch_in,
  output logic [data_w-1:0]  outa,
  output logic [data_w-1:0]  outb,
  output logic               branch_out
);

  logic                 inst_we;
  logic [pc_w-1:0]      inst_addr;
  logic [inst_w-1:0]    inst_data;
  logic                 const_we;
  logic [rf_addr_w-1:0] const_addr;
  logic [data_w-1:0]    const_data;
  logic                 pc_max_we, pc_loop_we;
  logic [pc_w-1:0]      pc_bound;
  logic [thread_w-1:0]  conf_thread;
  logic                 rf_re, rf_we;
  logic [thread_w-1:0]  rf_rthread, rf_wthread;
  logic [rf_addr_w-1:0] rf_raddr, rf_waddr;
  alu_op_e              alu_op;
  logic                 b_sel, out_a_en, out_b_en;
  logic [data_w-1:0]    rf_data, wr_data;

  pe_conf_reader #(.PE_ID(PE_ID)) conf_reader (
    .clk, .rst_n, .conf_bus,
    .inst_we, .inst_addr, .inst_data,
    .const_we, .const_addr, .const_data,
    .pc_max_we, .pc_loop_we, .pc_bound, .conf_thread
  );

  pe_ctrl ctrl (
    .clk, .rst_n, .en,
    .inst_we, .inst_addr, .inst_data,
    .pc_max_we, .pc_loop_we, .pc_bound, .conf_thread,
    .rf_re, .rf_rthread, .rf_raddr,
    .rf_we, .rf_wthread, .rf_waddr,
    .alu_op, .b_sel, .out_a_en, .out_b_en
  );

  pe_regfile regfile (
    .clk, .rst_n, .en,
    .rf_re, .rf_rthread, .rf_raddr,
    .rf_we, .rf_wthread, .rf_waddr, .wr_data,
    .const_we, .const_addr, .const_data,
    .const_thread(conf_thread),
    .rf_data
  );

  pe_exec exec (
    .clk, .rst_n, .en,
    .ina, .inb, .branch_in,
    .alu_op, .b_sel, .out_a_en, .out_b_en,
    .rf_data, .wr_data,
    .outa, .outb, .branch_out
  );

endmodule

`default_nettype wire

/* testbench/tb_cgra_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cgra_pe import cgra_pkg::*; ();

  localparam logic [pe_id_w-1:0] my_id = 8'd5;

  typedef struct packed {
    logic              vld;
    logic              oa;
    logic              ob;
    logic              we;
    logic              fl;
    logic [6:0]        waddr;
    logic [data_w-1:0] res;
  } inflight_t;

  logic              clk;
  logic              rst_n;
  logic              en;
  logic [conf_w-1:0] conf_bus;
  logic [data_w-1:0] ina, inb;
  logic              branch_in;
  logic [data_w-1:0] outa, outb;
  logic              branch_out;

  // reference model
  logic [inst_w-1:0]   m_imem [imem_depth];
  logic [data_w-1:0]   m_rf   [rf_depth];
  logic [pc_w-1:0]     m_pc   [num_threads];
  logic [pc_w-1:0]     m_max  [num_threads];
  logic [pc_w-1:0]     m_loop [num_threads];
  logic [thread_w-1:0] m_thr;
  inflight_t           pipe [3]; // index 0 = fetched at the last enabled edge
  logic [data_w-1:0]   exp_outa, exp_outb;
  logic                exp_br;

  logic running;
  logic freeze_on;
  int   hold_left;

  cgra_pe #(.PE_ID(my_id)) dut0 (
    .clk, .rst_n, .en, .conf_bus, .ina, .inb, .branch_in,
    .outa, .outb, .branch_out
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic end_with_failure(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input logic [data_w-1:0] got,
                                 input logic [data_w-1:0] exp);
    end_with_failure($sformatf("FAIL %0t %s got %h expected %h", $time, name, got, exp));
  endtask

  a_outa: assert property (@(posedge clk) disable iff (!rst_n) outa == exp_outa)
    else report_mismatch("outa", $sampled(outa), $sampled(exp_outa));
  a_outb: assert property (@(posedge clk) disable iff (!rst_n) outb == exp_outb)
    else report_mismatch("outb", $sampled(outb), $sampled(exp_outb));
  a_branch: assert property (@(posedge clk) disable iff (!rst_n) branch_out == exp_br)
    else report_mismatch("branch_out", 16'($sampled(branch_out)), 16'($sampled(exp_br)));
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !en |=> $stable(outa) && $stable(outb) && $stable(branch_out))
    else end_with_failure($sformatf("outputs changed at %0t after a cycle with en low", $time));

  function automatic logic [data_w-1:0] alu_ref(input logic [3:0] op,
      input logic [data_w-1:0] a, input logic [data_w-1:0] b, input logic br);
    case (op)
      ALU_PASS_A: return a;
      ALU_ADD:    return a + b;
      ALU_SUB:    return a - b;
      ALU_AND:    return a & b;
      ALU_OR:     return a | b;
      ALU_XOR:    return a ^ b;
      ALU_SHL:    return a << b[3:0];
      ALU_SHR:    return a >> b[3:0];
      ALU_SLT:    return (a < b) ? 16'd1 : 16'd0;
      ALU_EQ:     return (a == b) ? 16'd1 : 16'd0;
      ALU_SEL:    return br ? a : b;
      default:    return 16'd0;
    endcase
  endfunction

  function automatic logic [inst_w-1:0] encode_inst(input alu_op_e op, input logic bsel,
      input logic we, input logic oa, input logic ob, input logic [3:0] ra,
      input logic [3:0] wa);
    return {op, bsel, we, oa, ob, ra, wa};
  endfunction

  task automatic model_edge();
    logic [inst_w-1:0]   ins;
    logic [data_w-1:0]   b_val;
    logic [thread_w-1:0] t;
    t = m_thr;
    ins = m_imem[{t, m_pc[t]}];
    if (pipe[2].vld && pipe[2].we) begin
      m_rf[pipe[2].waddr] = pipe[2].res; // write lands one edge after the outputs
    end
    if (pipe[1].vld) begin
      if (pipe[1].oa) exp_outa = pipe[1].res;
      if (pipe[1].ob) exp_outb = pipe[1].res;
      if (pipe[1].fl) exp_br = pipe[1].res[0];
    end
    pipe[2] = pipe[1];
    pipe[1] = pipe[0];
    b_val = ins[11] ? m_rf[{t, ins[7:4]}] : inb;
    pipe[0].vld   = 1'b1;
    pipe[0].we    = ins[10];
    pipe[0].oa    = ins[9];
    pipe[0].ob    = ins[8];
    pipe[0].waddr = {t, ins[3:0]};
    pipe[0].fl    = (ins[15:12] == ALU_SLT) || (ins[15:12] == ALU_EQ);
    pipe[0].res   = alu_ref(ins[15:12], ina, b_val, branch_in);
    m_pc[t] = (m_pc[t] == m_max[t]) ? m_loop[t] : m_pc[t] + 8'd1;
    m_thr = t + 3'd1;
  endtask

  task automatic drive_inputs();
    ina = 16'($urandom);
    inb = ($urandom % 4 == 0) ? ina : 16'($urandom); // equal operands now and then
    branch_in = 1'($urandom);
    if (!running) begin
      en = 1'b0;
    end else if (hold_left > 0) begin
      en = 1'b0;
      hold_left--;
    end else if (freeze_on && ($urandom % 6 == 0)) begin
      en = 1'b0;
      hold_left = $urandom % 4;
    end else begin
      en = 1'b1;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
    if (rst_n && en) model_edge();
    drive_inputs();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic send_conf(input conf_cmd_e cmd, input logic [pe_id_w-1:0] id,
      input logic [thread_w-1:0] thr, input logic [pc_w-1:0] addr,
      input logic [data_w-1:0] data);
    conf_bus = {cmd, id, thr, addr, data, 26'd0};
    if (id == my_id) begin
      case (cmd)
        CONF_INST:    m_imem[{thr, addr}] = data;
        CONF_CONST:   m_rf[{thr, addr[3:0]}] = data;
        CONF_PC_MAX:  m_max[thr] = data[7:0];
        CONF_PC_LOOP: m_loop[thr] = data[7:0];
        default: ;
      endcase
    end
    next_cycle();
    conf_bus = '0;
  endtask

  task automatic load_inst(input logic [thread_w-1:0] thr, input logic [pc_w-1:0] addr,
                           input logic [inst_w-1:0] inst);
    send_conf(CONF_INST, my_id, thr, addr, inst);
  endtask

  task automatic clear_slots();
    for (int t = 0; t < num_threads; t++) begin
      load_inst(3'(t), 8'd0, '0);
    end
  endtask

  task automatic reset_dut();
    running = 1'b0;
    en = 1'b0;
    rst_n = 1'b0;
    for (int i = 0; i < num_threads; i++) begin
      m_pc[i] = '0;
      m_max[i] = '0;
      m_loop[i] = '0;
    end
    for (int i = 0; i < 3; i++) pipe[i] = '0;
    m_thr = '0;
    exp_outa = '0;
    exp_outb = '0;
    exp_br = 1'b0;
    repeat (8) next_cycle();
    rst_n = 1'b1;
  endtask

  task automatic start_run();
    conf_bus = '0;
    repeat (2) next_cycle(); // let the last config word land
    running = 1'b1;
    drive_inputs();
  endtask

  task automatic wait_output_change(input logic on_b, input string what);
    logic [data_w-1:0] start;
    int n;
    start = on_b ? outb : outa;
    n = 0;
    while ((on_b ? outb : outa) == start) begin
      if (n == 64) begin
        end_with_failure($sformatf("timeout waiting for %s to change in the %s test",
                                   on_b ? "outb" : "outa", what));
      end else begin
        next_cycle();
        n++;
      end
    end
  endtask

  initial begin
    alu_op_e rot_ops [num_threads];
    rot_ops = '{ALU_PASS_A, ALU_ADD, ALU_AND, ALU_OR, ALU_SHL, ALU_SHR, ALU_SUB, ALU_XOR};
    void'($urandom(32'h987d6c09));
    rst_n = 1'b0;
    en = 1'b0;
    conf_bus = '0;
    ina = '0;
    inb = '0;
    branch_in = 1'b0;
    running = 1'b0;
    freeze_on = 1'b0;
    hold_left = 0;

    reset_dut();
    clear_slots();
    load_inst(3'd0, 8'd0, encode_inst(ALU_ADD, 1'b0, 1'b0, 1'b1, 1'b0, 4'd0, 4'd0));
    start_run();
    wait_output_change(1'b0, "add");
    run_cycles(40);

    reset_dut();
    clear_slots();
    load_inst(3'd0, 8'd0, encode_inst(ALU_XOR, 1'b0, 1'b0, 1'b0, 1'b1, 4'd0, 4'd0));
    start_run();
    wait_output_change(1'b1, "xor");
    // words for PE 4 must be dropped
    send_conf(CONF_INST, 8'd4, 3'd0, 8'd0,
              encode_inst(ALU_SUB, 1'b0, 1'b0, 1'b1, 1'b1, 4'd0, 4'd0));
    send_conf(CONF_PC_MAX, 8'd4, 3'd0, 8'd0, 16'd3);
    run_cycles(40);

    reset_dut();
    clear_slots();
    send_conf(CONF_CONST, my_id, 3'd2, 8'd3, 16'($urandom));
    load_inst(3'd2, 8'd0, encode_inst(ALU_SUB, 1'b1, 1'b1, 1'b1, 1'b0, 4'd3, 4'd4));
    load_inst(3'd2, 8'd1, encode_inst(ALU_ADD, 1'b1, 1'b0, 1'b0, 1'b1, 4'd4, 4'd0));
    send_conf(CONF_PC_MAX, my_id, 3'd2, 8'd0, 16'd1);
    start_run();
    wait_output_change(1'b0, "register file");
    run_cycles(60);

    reset_dut();
    for (int t = 0; t < num_threads; t++) begin
      load_inst(3'(t), 8'd0, encode_inst(rot_ops[t], 1'b0, 1'b0, !t[0], t[0] | t[2], 4'd0, 4'd0));
    end
    load_inst(3'd1, 8'd1, encode_inst(ALU_SUB, 1'b0, 1'b0, 1'b0, 1'b1, 4'd0, 4'd0));
    load_inst(3'd1, 8'd2, encode_inst(ALU_XOR, 1'b0, 1'b0, 1'b1, 1'b1, 4'd0, 4'd0));
    send_conf(CONF_PC_MAX, my_id, 3'd1, 8'd0, 16'd2);
    send_conf(CONF_PC_LOOP, my_id, 3'd1, 8'd0, 16'd1);
    start_run();
    wait_output_change(1'b0, "thread rotation");
    run_cycles(60);
    freeze_on = 1'b1;
    run_cycles(200);
    freeze_on = 1'b0;

    reset_dut();
    clear_slots();
    load_inst(3'd0, 8'd0, encode_inst(ALU_SLT, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0, 4'd0));
    load_inst(3'd3, 8'd0, encode_inst(ALU_EQ, 1'b0, 1'b0, 1'b0, 1'b0, 4'd0, 4'd0));
    load_inst(3'd5, 8'd0, encode_inst(ALU_SEL, 1'b0, 1'b0, 1'b1, 1'b0, 4'd0, 4'd0));
    load_inst(3'd6, 8'd0, encode_inst(ALU_SEL, 1'b0, 1'b0, 1'b0, 1'b1, 4'd0, 4'd0));
    start_run();
    wait_output_change(1'b0, "select");
    freeze_on = 1'b1;
    run_cycles(150);

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
common/cgra_pkg.sv
pe/pe_conf_reader.sv
pe/pe_ctrl.sv
pe/pe_regfile.sv
pe/pe_exec.sv
rtl/cgra_pe.sv
testbench/tb_cgra_pe.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cgra_pe
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP SEED OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f vlog.f
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJ_DIR)
